//--- verilog/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    // All zero means read
    typedef logic [3:0]  bus_strb_t;

    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        bus_strb_t wstrb;
    } bus_req_t;

    // Byte offset bits below the word address
    localparam int WORD_LSB = 2;

    // RAM below, I/O from here up
    localparam bus_addr_t IO_BASE = 32'h8000_0000;

    // Offsets from IO_BASE
    localparam bus_addr_t REG_LED         = 32'h0000_0000;
    localparam bus_addr_t REG_DIP         = 32'h0000_0004;
    localparam bus_addr_t REG_BTN         = 32'h0000_0008;
    localparam bus_addr_t REG_AUDIO_STAT  = 32'h0000_0010;
    localparam bus_addr_t REG_AUDIO_LEFT  = 32'h0000_0014;
    localparam bus_addr_t REG_AUDIO_RIGHT = 32'h0000_0018;

endpackage

`default_nettype wire

//--- verilog/audio_pkg.sv
`default_nettype none

package audio_pkg;

    typedef logic signed [23:0] sample_t;

    // Left in the upper half, as in the 48-bit audio word
    typedef struct packed {
        sample_t left;
        sample_t right;
    } audio_frame_t;

    // Chip address, register address, data
    typedef logic [31:0] spi_word_t;

    localparam int INIT_LEN = 6;

    // Clock on, slave port, mixers and DAC up
    localparam spi_word_t INIT_TABLE [INIT_LEN] = '{
        32'h00_4000_01,
        32'h00_4015_00,
        32'h00_401C_21,
        32'h00_401E_41,
        32'h00_4029_03,
        32'h00_402A_03
    };

    typedef enum logic [1:0] {IDLE, SHIFT, LATCH, DONE} adau_state_t;

endpackage

`default_nettype wire

//--- verilog/cpu_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ram
    import soc_bus_pkg::*;
#(
    parameter int RAM_ADDR_W = 15
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      valid,
    input  bus_req_t  req,
    output logic      ready,
    output bus_data_t rdata
);

    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

    bus_data_t mem [2**RAM_ADDR_W];
    ram_addr_t word_addr;
    logic      access;

    assign word_addr = req.addr[RAM_ADDR_W+WORD_LSB-1:WORD_LSB];

    // Only the first cycle of a request counts
    assign access = valid && !ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.wstrb[lane]) begin
                    mem[word_addr][8*lane +: 8] <= req.wdata[8*lane +: 8];
                end
            end
            rdata <= mem[word_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/cpu_bus_logic.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_logic
    import soc_bus_pkg::*;
    import audio_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         valid,
    input  bus_req_t     req,
    output logic         ready,
    output bus_data_t    rdata,

    input  logic [7:0]   dip,
    input  logic [4:0]   buttons,
    output logic [7:0]   led,

    output logic         ram_valid,
    output bus_req_t     ram_req,
    input  bus_data_t    ram_rdata,
    input  logic         ram_ready,

    output logic         audio_push,
    output audio_frame_t audio_frame,
    input  logic         audio_full,
    input  logic         init_done
);

    bus_addr_t io_off;
    bus_data_t io_rdata;
    sample_t   left_stage;
    logic      io_sel;
    logic      io_valid;
    logic      io_wr;
    logic      wr_right;
    logic      io_go;
    logic      io_ready;

    assign io_sel   = (req.addr >= IO_BASE);
    assign io_off   = req.addr - IO_BASE;
    assign io_valid = valid && io_sel;
    assign io_wr    = |req.wstrb;
    assign wr_right = io_wr && (io_off == REG_AUDIO_RIGHT);

    // Right sample write waits here while the FIFO is full
    assign io_go = io_valid && !io_ready && !(wr_right && audio_full);

    assign ram_valid = valid && !io_sel;
    assign ram_req   = req;

    assign audio_push  = io_go && wr_right;
    assign audio_frame = '{left: left_stage, right: sample_t'(req.wdata[23:0])};

    assign ready = ram_ready || io_ready;
    assign rdata = ram_ready ? ram_rdata : io_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_ready <= 1'b0;
            led      <= '0;
        end else begin
            io_ready <= io_go;
            // Only lane 0 reaches the LEDs
            if (io_go && (io_off == REG_LED) && req.wstrb[0]) begin
                led <= req.wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (io_go && io_wr && (io_off == REG_AUDIO_LEFT)) begin
            left_stage <= sample_t'(req.wdata[23:0]);
        end
    end

    // Unmapped offsets read zero
    always_ff @(posedge clk) begin
        if (io_go) begin
            case (io_off)
                REG_LED:        io_rdata <= {24'h0, led};
                REG_DIP:        io_rdata <= {24'h0, dip};
                REG_BTN:        io_rdata <= {27'h0, buttons};
                REG_AUDIO_STAT: io_rdata <= {30'h0, init_done, audio_full};
                default:        io_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/adau_sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module adau_sample_fifo
    import audio_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         push,
    input  audio_frame_t din,
    input  logic         pop,
    output audio_frame_t dout,
    output logic         full,
    output logic         empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   count_t;

    audio_frame_t mem [FIFO_DEPTH];
    ptr_t         wr_ptr;
    ptr_t         rd_ptr;
    count_t       count;
    logic         do_push;
    logic         do_pop;

    function automatic ptr_t ptr_inc(input ptr_t ptr);
        return (ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == count_t'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + count_t'(do_push) - count_t'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

//--- verilog/adau_interface.sv
`timescale 1ns/1ps
`default_nettype none

module adau_interface
    import audio_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int BCLK_DIV   = 2,
    parameter int CCLK_DIV   = 2
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         audio_push,
    input  audio_frame_t audio_frame,
    output logic         audio_full,
    output logic         init_done,
    output logic         cclk,
    output logic         clatch_n,
    output logic         cdata,
    output logic         sdata,
    output logic         bclk,
    output logic         lrclk
);

    typedef logic [$clog2(CCLK_DIV+1)-1:0] cdiv_t;
    typedef logic [$clog2(BCLK_DIV+1)-1:0] bdiv_t;
    typedef logic [$clog2(INIT_LEN+1)-1:0] init_idx_t;
    typedef logic [4:0]  spi_bit_t;
    typedef logic [5:0]  slot_bit_t;
    typedef logic [63:0] frame_bits_t;

    adau_state_t  spi_state;
    spi_word_t    spi_shift;
    spi_bit_t     spi_bit;
    init_idx_t    word_idx;
    cdiv_t        cclk_cnt;
    logic         cclk_tick;

    audio_frame_t fifo_dout;
    logic         fifo_empty;
    logic         fifo_pop;
    frame_bits_t  ser_shift;
    slot_bit_t    ser_bit;
    slot_bit_t    ser_bit_nx;
    bdiv_t        bclk_cnt;
    logic         bclk_tick;
    logic         bclk_fall;
    logic         ser_run;
    logic         frame_start;

    assign cclk_tick = (cclk_cnt == cdiv_t'(CCLK_DIV - 1));
    assign cdata     = spi_shift[31];
    assign init_done = (spi_state == DONE);

    // Control port init writes one table word per latch window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spi_state <= IDLE;
            spi_shift <= '0;
            spi_bit   <= '0;
            word_idx  <= '0;
            cclk_cnt  <= '0;
            cclk      <= 1'b0;
            clatch_n  <= 1'b1;
        end else begin
            case (spi_state)
                IDLE: begin
                    spi_shift <= INIT_TABLE[word_idx];
                    spi_bit   <= '0;
                    cclk_cnt  <= '0;
                    clatch_n  <= 1'b0;
                    spi_state <= SHIFT;
                end
                SHIFT: begin
                    cclk_cnt <= cclk_tick ? '0 : cclk_cnt + 1'b1;
                    if (cclk_tick) begin
                        cclk <= ~cclk;
                        // Falling edge moves to the next bit
                        if (cclk) begin
                            spi_shift <= spi_shift << 1;
                            spi_bit   <= spi_bit + 1'b1;
                            if (spi_bit == spi_bit_t'(31)) begin
                                clatch_n  <= 1'b1;
                                spi_state <= LATCH;
                            end
                        end
                    end
                end
                LATCH: begin
                    cclk_cnt <= cclk_tick ? '0 : cclk_cnt + 1'b1;
                    if (cclk_tick) begin
                        word_idx  <= word_idx + 1'b1;
                        spi_state <= (word_idx == init_idx_t'(INIT_LEN - 1)) ? DONE : IDLE;
                    end
                end
                default: cclk <= 1'b0;
            endcase
        end
    end

    adau_sample_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_i (
        .clk  (clk),
        .rst_n(rst_n),
        .push (audio_push),
        .din  (audio_frame),
        .pop  (fifo_pop),
        .dout (fifo_dout),
        .full (audio_full),
        .empty(fifo_empty)
    );

    assign bclk_tick   = (bclk_cnt == bdiv_t'(BCLK_DIV - 1));
    assign bclk_fall   = ser_run && bclk_tick && bclk;
    assign ser_bit_nx  = ser_bit + 1'b1;
    assign frame_start = (init_done && !ser_run) || (bclk_fall && (ser_bit == '1));
    assign fifo_pop    = frame_start && !fifo_empty;
    assign sdata       = ser_shift[63];

    // 64 bit clocks per frame with 24-bit samples left justified in 32-bit slots
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ser_run   <= 1'b0;
            bclk_cnt  <= '0;
            bclk      <= 1'b0;
            lrclk     <= 1'b0;
            ser_bit   <= '0;
            ser_shift <= '0;
        end else begin
            if (init_done) begin
                ser_run <= 1'b1;
            end
            if (ser_run) begin
                bclk_cnt <= bclk_tick ? '0 : bclk_cnt + 1'b1;
                if (bclk_tick) begin
                    bclk <= ~bclk;
                end
            end
            if (bclk_fall) begin
                ser_bit   <= ser_bit_nx;
                lrclk     <= ser_bit_nx[5];
                ser_shift <= ser_shift << 1;
            end
            // Silence when nothing is queued
            if (frame_start) begin
                ser_shift <= fifo_pop ? {fifo_dout.left, 8'h00, fifo_dout.right, 8'h00} : '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/soc_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_io_top
    import soc_bus_pkg::*;
    import audio_pkg::*;
#(
    parameter int RAM_ADDR_W = 15,
    parameter int FIFO_DEPTH = 4,
    parameter int BCLK_DIV   = 2,
    parameter int CCLK_DIV   = 2
) (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       valid,
    input  bus_req_t   req,
    output logic       ready,
    output bus_data_t  rdata,

    input  logic [7:0] dip,
    input  logic [4:0] buttons,
    output logic [7:0] led,

    // Codec control port
    output logic       cclk,
    output logic       clatch_n,
    output logic       cdata,

    // Codec serial audio
    output logic       sdata,
    output logic       bclk,
    output logic       lrclk
);

    bus_req_t     ram_req;
    bus_data_t    ram_rdata;
    logic         ram_valid;
    logic         ram_ready;
    audio_frame_t audio_frame;
    logic         audio_push;
    logic         audio_full;
    logic         init_done;

    cpu_bus_logic bus_logic_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (valid),
        .req        (req),
        .ready      (ready),
        .rdata      (rdata),
        .dip        (dip),
        .buttons    (buttons),
        .led        (led),
        .ram_valid  (ram_valid),
        .ram_req    (ram_req),
        .ram_rdata  (ram_rdata),
        .ram_ready  (ram_ready),
        .audio_push (audio_push),
        .audio_frame(audio_frame),
        .audio_full (audio_full),
        .init_done  (init_done)
    );

    cpu_ram #(
        .RAM_ADDR_W(RAM_ADDR_W)
    ) ram_i (
        .clk  (clk),
        .rst_n(rst_n),
        .valid(ram_valid),
        .req  (ram_req),
        .ready(ram_ready),
        .rdata(ram_rdata)
    );

    adau_interface #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .BCLK_DIV  (BCLK_DIV),
        .CCLK_DIV  (CCLK_DIV)
    ) adau_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .audio_push (audio_push),
        .audio_frame(audio_frame),
        .audio_full (audio_full),
        .init_done  (init_done),
        .cclk       (cclk),
        .clatch_n   (clatch_n),
        .cdata      (cdata),
        .sdata      (sdata),
        .bclk       (bclk),
        .lrclk      (lrclk)
    );

endmodule

`default_nettype wire

//--- tests/soc_io_chk.sv
`timescale 1ns/1ps
`default_nettype none

module soc_io_chk
    import soc_bus_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     valid,
    input logic     ready,
    input bus_req_t req,
    input logic     push,
    input logic     full,
    input logic     empty
);

    int fail_count = 0;

    // Master holds the request until the handshake
    assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready |=> valid && $stable(req))
    else begin
        fail_count++;
        $error("request changed or dropped before ready");
    end

    assert property (@(posedge clk) disable iff (!rst_n) ready |-> valid)
    else begin
        fail_count++;
        $error("ready high without valid");
    end

    assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else begin
        fail_count++;
        $error("audio push while FIFO full");
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(full && empty))
    else begin
        fail_count++;
        $error("FIFO full and empty together");
    end

endmodule

// The bus side has no empty level and the FIFO side has no bus
bind cpu_bus_logic soc_io_chk chk_i (
    .clk  (clk),
    .rst_n(rst_n),
    .valid(valid),
    .ready(ready),
    .req  (req),
    .push (audio_push),
    .full (audio_full),
    .empty(1'b0)
);

bind adau_sample_fifo soc_io_chk chk_i (
    .clk  (clk),
    .rst_n(rst_n),
    .valid(1'b0),
    .ready(1'b0),
    .req  ('0),
    .push (push),
    .full (full),
    .empty(empty)
);

`default_nettype wire

//--- tests/soc_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_io_tb
    import soc_bus_pkg::*;
    import audio_pkg::*;
();

    localparam int RAM_ADDR_W    = 15;
    localparam int FIFO_DEPTH    = 4;
    localparam int BCLK_DIV      = 2;
    localparam int CCLK_DIV      = 2;
    localparam int BUS_TIMEOUT   = 2000;
    localparam int INIT_TIMEOUT  = 1000;
    localparam int DRAIN_TIMEOUT = 20000;

    logic       clk;
    logic       rst_n;
    logic       valid;
    bus_req_t   req;
    logic       ready;
    bus_data_t  rdata;
    logic [7:0] dip;
    logic [4:0] buttons;
    logic [7:0] led;
    logic       cclk;
    logic       clatch_n;
    logic       cdata;
    logic       sdata;
    logic       bclk;
    logic       lrclk;

    // Reference model state
    bus_data_t  ram_model [bus_addr_t];
    logic [7:0] led_model = '0;
    logic       init_model = 1'b0;

    string        cmp_name [$];
    bus_data_t    cmp_exp [$];
    bus_data_t    cmp_act [$];
    audio_frame_t exp_frames [$];
    spi_word_t    spi_shift_in = '0;
    int           spi_bits = 0;
    int           spi_count = 0;
    logic [63:0]  ser_bits = '0;
    int           ser_idx = 0;
    bit           full_seen = 1'b0;

    soc_io_top #(
        .RAM_ADDR_W(RAM_ADDR_W),
        .FIFO_DEPTH(FIFO_DEPTH),
        .BCLK_DIV  (BCLK_DIV),
        .CCLK_DIV  (CCLK_DIV)
    ) soc_io_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid   (valid),
        .req     (req),
        .ready   (ready),
        .rdata   (rdata),
        .dip     (dip),
        .buttons (buttons),
        .led     (led),
        .cclk    (cclk),
        .clatch_n(clatch_n),
        .cdata   (cdata),
        .sdata   (sdata),
        .bclk    (bclk),
        .lrclk   (lrclk)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_spi(input string name, input spi_word_t exp, input spi_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_frame(input string name, input audio_frame_t exp,
                               input audio_frame_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // Expected read data; writes update the model
    function automatic bus_data_t ref_access(input bus_addr_t addr, input bus_data_t wdata,
                                             input bus_strb_t wstrb);
        bus_addr_t word_idx;
        bus_data_t cur;
        if (addr < IO_BASE) begin
            word_idx = addr[RAM_ADDR_W+1:2];
            cur = ram_model.exists(word_idx) ? ram_model[word_idx] : 'x;
            for (int lane = 0; lane < 4; lane++) begin
                if (wstrb[lane]) begin
                    cur[8*lane +: 8] = wdata[8*lane +: 8];
                end
            end
            if (wstrb != '0) begin
                ram_model[word_idx] = cur;
            end
            return cur;
        end
        case (addr - IO_BASE)
            REG_LED: begin
                if (wstrb[0]) begin
                    led_model = wdata[7:0];
                end
                return {24'h0, led_model};
            end
            REG_DIP:        return {24'h0, dip};
            REG_BTN:        return {27'h0, buttons};
            // Full bit is masked by the caller
            REG_AUDIO_STAT: return {30'h0, init_model, 1'b0};
            default:        return '0;
        endcase
    endfunction

    task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata,
                              input bus_strb_t wstrb, output bus_data_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        valid = 1'b1;
        req = '{addr: addr, wdata: wdata, wstrb: wstrb};
        do begin
            @(negedge clk);
            waited++;
            if (waited > BUS_TIMEOUT) begin
                abort_run($sformatf("bus access to %h never got ready", addr));
            end
        end while (!ready);
        data = rdata;
        // Hold through the handshake edge
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t wdata,
                             input bus_strb_t wstrb);
        bus_data_t unused;
        bus_access(addr, wdata, wstrb, unused);
        void'(ref_access(addr, wdata, wstrb));
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        bus_access(addr, '0, '0, data);
    endtask

    task automatic check_read(input string name, input bus_addr_t addr);
        bus_data_t exp;
        bus_data_t data;
        exp = ref_access(addr, '0, '0);
        bus_read(addr, data);
        cmp_name.push_back(name);
        cmp_exp.push_back(exp);
        cmp_act.push_back(data);
    endtask

    task automatic send_pair();
        audio_frame_t frame;
        frame.left = sample_t'($urandom);
        frame.right = sample_t'($urandom);
        if (frame.left == '0) begin
            frame.left = 24'sd1;
        end
        if (frame.right == '0) begin
            frame.right = 24'sd1;
        end
        exp_frames.push_back(frame);
        bus_write(IO_BASE + REG_AUDIO_LEFT, {8'h00, frame.left}, 4'hf);
        bus_write(IO_BASE + REG_AUDIO_RIGHT, {8'h00, frame.right}, 4'hf);
    endtask

    task automatic wait_frames_drained();
        int waited;
        waited = 0;
        while (exp_frames.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("pushed audio frames did not all appear on sdata");
            end
        end
    endtask

    always @(posedge clk) begin
        while (cmp_act.size() > 0) begin
            check_data(cmp_name.pop_front(), cmp_exp.pop_front(), cmp_act.pop_front());
        end
    end

    // cdata sampled on rising cclk inside the latch window
    always @(posedge cclk) begin
        if (!clatch_n) begin
            spi_shift_in = {spi_shift_in[30:0], cdata};
            spi_bits++;
        end
    end

    always @(posedge clatch_n) begin
        if (spi_bits != 0) begin
            if (spi_bits != 32) begin
                abort_run($sformatf("SPI word %0d had %0d bits", spi_count, spi_bits));
            end
            if (spi_count >= INIT_LEN) begin
                abort_run("SPI init wrote more words than the init table holds");
            end
            check_spi("spi_init", INIT_TABLE[spi_count], spi_shift_in);
            spi_count++;
            spi_bits = 0;
        end
    end

    always @(posedge bclk) begin
        audio_frame_t got;
        if (lrclk !== (ser_idx >= 32)) begin
            abort_run($sformatf("lrclk wrong at bit %0d of the frame", ser_idx));
        end
        ser_bits = {ser_bits[62:0], sdata};
        ser_idx++;
        if (ser_idx == 64) begin
            ser_idx = 0;
            if (ser_bits[39:32] !== 8'h00 || ser_bits[7:0] !== 8'h00) begin
                abort_run("padding bits of an audio slot are not zero");
            end
            got = '{left: ser_bits[63:40], right: ser_bits[31:8]};
            // Idle frames are silence
            if (got !== '0) begin
                if (exp_frames.size() == 0) begin
                    abort_run("audio frame on sdata that was never pushed");
                end
                check_frame("audio_order", exp_frames.pop_front(), got);
            end
        end
    end

    initial begin
        bus_data_t data;
        bus_addr_t addrs [8];
        int        waited;
        void'($urandom(32'hf02f));
        clk = 1'b0;
        rst_n = 1'b0;
        valid = 1'b0;
        req = '0;
        dip = '0;
        buttons = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // RAM byte merge
        for (int i = 0; i < 8; i++) begin
            addrs[i] = bus_addr_t'($urandom % (1 << RAM_ADDR_W)) << 2;
            bus_write(addrs[i], $urandom, 4'hf);
            bus_write(addrs[i], $urandom, bus_strb_t'($urandom));
        end
        for (int i = 0; i < 8; i++) begin
            check_read("ram_merge", addrs[i]);
        end

        // LEDs, switches, buttons
        for (int i = 0; i < 4; i++) begin
            bus_write(IO_BASE + REG_LED, $urandom, bus_strb_t'($urandom));
            check_data("led_port", {24'h0, led_model}, {24'h0, led});
            check_read("led_readback", IO_BASE + REG_LED);
            dip = 8'($urandom);
            buttons = 5'($urandom);
            check_read("dip_read", IO_BASE + REG_DIP);
            check_read("btn_read", IO_BASE + REG_BTN);
        end
        bus_write(IO_BASE + 32'h0c, $urandom, 4'hf);
        check_read("unmapped_0c", IO_BASE + 32'h0c);
        bus_write(IO_BASE + 32'h1c, $urandom, 4'hf);
        check_read("unmapped_1c", IO_BASE + 32'h1c);
        check_read("unmapped_100", IO_BASE + 32'h100);

        // Codec init sequence
        waited = 0;
        do begin
            bus_read(IO_BASE + REG_AUDIO_STAT, data);
            waited++;
            if (waited > INIT_TIMEOUT) begin
                abort_run("init_done never set in the status word");
            end
        end while (!data[1]);
        if (spi_count != INIT_LEN) begin
            abort_run($sformatf("SPI monitor saw %0d init words, not %0d", spi_count, INIT_LEN));
        end
        init_model = 1'b1;
        check_read("init_status", IO_BASE + REG_AUDIO_STAT);

        for (int i = 0; i < 3; i++) begin
            send_pair();
        end
        wait_frames_drained();

        // More pairs than the FIFO holds
        for (int i = 0; i < 10; i++) begin
            send_pair();
            bus_read(IO_BASE + REG_AUDIO_STAT, data);
            check_data("status_bits", ref_access(IO_BASE + REG_AUDIO_STAT, '0, '0),
                       data & ~32'h1);
            if (data[0]) begin
                full_seen = 1'b1;
            end
        end
        wait_frames_drained();
        if (!full_seen) begin
            abort_run("status full bit never seen while writing ten pairs");
        end

        @(posedge clk);
        @(negedge clk);
        if (cmp_act.size() == 0 && soc_io_top_i.bus_logic_i.chk_i.fail_count == 0 &&
            soc_io_top_i.adau_i.fifo_i.chk_i.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run("bound protocol assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

//--- project.f
verilog/soc_bus_pkg.sv
verilog/audio_pkg.sv
verilog/cpu_ram.sv
verilog/cpu_bus_logic.sv
verilog/adau_sample_fifo.sv
verilog/adau_interface.sv
verilog/soc_io_top.sv
tests/soc_io_chk.sv
tests/soc_io_tb.sv
